/* Bender.yml */
package:
  name: pcir_mstr

sources:
  - design/pcir_cfg_pkg.sv
  - design/pcir_axi_pkg.sv
  - design/pcir_cfg_regs.sv
  - design/pcir_inst_table.sv
  - design/pcir_read_issue.sv
  - design/pcir_read_queues.sv
  - design/pcir_mstr_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/pcir_mstr_tb.sv

/* build.f */
+incdir+test
design/pcir_cfg_pkg.sv
design/pcir_axi_pkg.sv
design/pcir_cfg_regs.sv
design/pcir_inst_table.sv
design/pcir_read_issue.sv
design/pcir_read_queues.sv
design/pcir_mstr_top.sv
test/pcir_mstr_tb.sv

/* design/pcir_axi_pkg.sv */
// ------------------------------------------------
// AXI read-channel types for the read master.
// ------------------------------------------------
package pcir_axi_pkg;

   // Fixed number of outstanding read IDs.
   localparam int unsigned num_ids = 4;

   typedef logic [15:0]                axi_id_t;
   typedef logic [$clog2(num_ids)-1:0] id_idx_t;

   // 8-byte beats on a 64-bit data bus.
   localparam int unsigned beat_bytes_log2 = 3;

   // Read address channel payload.
   typedef struct packed {
      axi_id_t     id;
      logic [63:0] addr;
      logic [7:0]  len;
      logic [2:0]  size;
   } axi_ar_t;

   // Read data channel payload.
   typedef struct packed {
      axi_id_t     id;
      logic [63:0] data;
      logic [1:0]  resp;
      logic        last;
   } axi_r_t;

endpackage

/* design/pcir_cfg_pkg.sv */
// ------------------------------------------------
// Configuration package for the host-memory read master.
// Register map, port and queue sizing, config bus types.
// ------------------------------------------------
package pcir_cfg_pkg;

   // Port and queue sizing.
   localparam int unsigned num_ports = 2;
   localparam int unsigned q_depth   = 4;

   typedef logic [$clog2(num_ports)-1:0] port_idx_t;
   typedef logic [$clog2(q_depth)-1:0]   q_idx_t;
   typedef logic [63:0]                  port_data_t;

   // Last valid entry index of each port queue.
   typedef q_idx_t [num_ports-1:0] q_size_arr_t;

   // One read instruction: base address and burst length minus one.
   typedef struct packed {
      logic [63:0] addr;
      logic [7:0]  len;
   } inst_t;

   // Config bus request and response.
   typedef struct packed {
      logic [7:0]  addr;
      logic [31:0] wdata;
      logic        wr;
      logic        rd;
   } cfg_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] rdata;
   } cfg_rsp_t;

   // ------------------------------------------------
   // Register offsets.
   // ------------------------------------------------
   localparam logic [7:0] reg_run        = 8'h00;
   localparam logic [7:0] reg_run_cycles = 8'h04;
   localparam logic [7:0] reg_inst_count = 8'h08;
   localparam logic [7:0] reg_inst_index = 8'h0C;
   localparam logic [7:0] reg_addr_lo    = 8'h10;
   localparam logic [7:0] reg_addr_hi    = 8'h14;
   localparam logic [7:0] reg_len        = 8'h18;
   localparam logic [7:0] reg_q_size     = 8'h1C;
   // Read only.
   localparam logic [7:0] reg_dut_cycles = 8'h20;

   // Returned for unmapped offsets.
   localparam logic [31:0] bad_reg_value = 32'hDEADBEEF;

endpackage

/* design/pcir_cfg_regs.sv */
// ------------------------------------------------
// Config register bank with two-cycle acknowledge.
// Holds the run limit and counts completed DUT cycles.
// ------------------------------------------------
module pcir_cfg_regs
   import pcir_cfg_pkg::*;
(
   input  logic        clk,
   input  logic        sync_rst_n,
   input  cfg_req_t    cfg_req,
   output cfg_rsp_t    cfg_rsp,
   input  logic        dut_cycle_done,
   output logic        run,
   output port_idx_t   inst_count,
   output q_size_arr_t q_size,
   output logic        inst_wr,
   output port_idx_t   inst_index,
   output inst_t       inst_wdata
);

   // Registered request, decoded one cycle after the strobe.
   cfg_req_t    req_q;
   logic        ack_q;
   logic [31:0] rdata_q;

   // Programmed state.
   logic        run_bit;
   logic [31:0] run_limit;
   logic [63:0] addr_r;
   logic [7:0]  len_r;

   // Completed DUT cycles.
   logic [31:0] dut_cycles;

   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         req_q <= '0;
         ack_q <= 1'b0;
      end else begin
         req_q <= cfg_req;
         // Ack lands two cycles after the strobe.
         ack_q <= req_q.wr | req_q.rd;
      end
   end

   // ------------------------------------------------
   // Register writes.
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         run_bit    <= 1'b0;
         run_limit  <= '0;
         inst_count <= '0;
         inst_index <= '0;
         addr_r     <= '0;
         len_r      <= '0;
         q_size     <= '0;
         inst_wr    <= 1'b0;
      end else begin
         // Writing the length commits the instruction.
         inst_wr <= req_q.wr && (req_q.addr == reg_len);
         if (req_q.wr) begin
            case (req_q.addr)
               reg_run:        run_bit <= req_q.wdata[0];
               reg_run_cycles: run_limit <= req_q.wdata;
               // A count equal to num_ports wraps to zero here.
               reg_inst_count: inst_count <= port_idx_t'(req_q.wdata);
               reg_inst_index: inst_index <= port_idx_t'(req_q.wdata);
               reg_addr_lo:    addr_r[31:0] <= req_q.wdata;
               reg_addr_hi:    addr_r[63:32] <= req_q.wdata;
               reg_len:        len_r <= req_q.wdata[7:0];
               reg_q_size:     q_size <= q_size_arr_t'(req_q.wdata[$bits(q_size_arr_t)-1:0]);
               default: ;
            endcase
         end
      end
   end

   // ------------------------------------------------
   // Readback mux, held until the next read.
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         rdata_q <= '0;
      end else if (req_q.rd) begin
         case (req_q.addr)
            reg_run:        rdata_q <= {31'b0, run_bit};
            reg_run_cycles: rdata_q <= run_limit;
            reg_inst_count: rdata_q <= 32'(inst_count);
            reg_inst_index: rdata_q <= 32'(inst_index);
            reg_addr_lo:    rdata_q <= addr_r[31:0];
            reg_addr_hi:    rdata_q <= addr_r[63:32];
            reg_len:        rdata_q <= {24'b0, len_r};
            reg_q_size:     rdata_q <= 32'(q_size);
            reg_dut_cycles: rdata_q <= dut_cycles;
            default:        rdata_q <= bad_reg_value;
         endcase
      end
   end

   assign cfg_rsp    = '{ack: ack_q, rdata: rdata_q};
   assign inst_wdata = '{addr: addr_r, len: len_r};

   // One count per dut_clocked that closed a delivery.
   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         dut_cycles <= '0;
      end else if (dut_cycle_done) begin
         dut_cycles <= dut_cycles + 32'd1;
      end
   end

   // Run stops once the limit is reached.
   assign run = run_bit && (dut_cycles != run_limit);

   // The bus never carries a read and a write at once.
   a_cfg_one_strobe: assert property (@(posedge clk) disable iff (!sync_rst_n)
      !(cfg_req.wr && cfg_req.rd));

endmodule

/* design/pcir_inst_table.sv */
// ------------------------------------------------
// Instruction table, one entry per DUT read port.
// ------------------------------------------------
module pcir_inst_table
   import pcir_cfg_pkg::*;
(
   input  logic      clk,
   input  logic      wr,
   input  port_idx_t wr_index,
   input  inst_t     wdata,
   input  port_idx_t rd_index,
   output inst_t     rdata
);

   // Small memory, one instruction per port.
   inst_t mem [num_ports];

   // Config side write.
   always_ff @(posedge clk) begin
      if (wr) begin
         mem[wr_index] <= wdata;
      end
   end

   // Registered read, data follows the index by one cycle.
   always_ff @(posedge clk) begin
      rdata <= mem[rd_index];
   end

endmodule

/* design/pcir_mstr_top.sv */
// ------------------------------------------------
// Host-memory read master, top level.
// ------------------------------------------------
module pcir_mstr_top
   import pcir_cfg_pkg::*;
   import pcir_axi_pkg::*;
(
   input  logic                       clk,
   input  logic                       sync_rst_n,
   input  cfg_req_t                   cfg_req,
   output cfg_rsp_t                   cfg_rsp,
   output axi_ar_t                    ar,
   output logic                       ar_valid,
   input  logic                       ar_ready,
   input  axi_r_t                     r,
   input  logic                       r_valid,
   output logic                       r_ready,
   input  logic [num_ports-1:0]       inst_active,
   input  logic                       dut_clocked,
   output port_data_t [num_ports-1:0] port_data,
   output logic                       read_sm_active
);

   // Config outputs.
   logic        run;
   port_idx_t   inst_count;
   q_size_arr_t q_size;
   logic        inst_wr;
   port_idx_t   inst_index;
   inst_t       inst_wdata;

   // Instruction table read port.
   port_idx_t inst_rd_index;
   inst_t     inst_rdata;

   // Issue to queue handoff.
   logic                              issue;
   id_idx_t                           issue_id;
   port_idx_t                         issue_port;
   q_idx_t                            issue_entry;
   logic [num_ports-1:0][q_depth-1:0] entry_busy;
   logic [num_ids-1:0]                id_busy;
   logic                              dut_cycle_done;

   pcir_cfg_regs u_cfg_regs (
      .clk, .sync_rst_n, .cfg_req, .cfg_rsp, .dut_cycle_done, .run,
      .inst_count, .q_size, .inst_wr, .inst_index, .inst_wdata
   );

   pcir_inst_table u_inst_table (
      .clk, .wr(inst_wr), .wr_index(inst_index), .wdata(inst_wdata),
      .rd_index(inst_rd_index), .rdata(inst_rdata)
   );

   pcir_read_issue u_read_issue (
      .clk, .sync_rst_n, .run, .inst_count, .q_size, .inst_rd_index,
      .inst(inst_rdata), .entry_busy, .id_busy, .issue, .issue_id,
      .issue_port, .issue_entry, .ar, .ar_valid, .ar_ready
   );

   pcir_read_queues u_read_queues (
      .clk, .sync_rst_n, .run, .q_size, .issue, .issue_id, .issue_port,
      .issue_entry, .entry_busy, .id_busy, .r, .r_valid, .r_ready,
      .inst_active, .dut_clocked, .port_data, .read_sm_active, .dut_cycle_done
   );

endmodule

/* design/pcir_read_issue.sv */
// ------------------------------------------------
// Read-issue FSM: walks every port and entry and
// issues one AXI read per empty queue entry.
// ------------------------------------------------
module pcir_read_issue
   import pcir_cfg_pkg::*;
   import pcir_axi_pkg::*;
(
   input  logic                              clk,
   input  logic                              sync_rst_n,
   input  logic                              run,
   input  port_idx_t                         inst_count,
   input  q_size_arr_t                       q_size,
   output port_idx_t                         inst_rd_index,
   input  inst_t                             inst,
   input  logic [num_ports-1:0][q_depth-1:0] entry_busy,
   input  logic [num_ids-1:0]                id_busy,
   output logic                              issue,
   output id_idx_t                           issue_id,
   output port_idx_t                         issue_port,
   output q_idx_t                            issue_entry,
   output axi_ar_t                           ar,
   output logic                              ar_valid,
   input  logic                              ar_ready
);

   typedef enum logic [1:0] {
      st_idle,
      st_start,
      st_read_inst,
      st_addr
   } issue_state_t;

   issue_state_t state, state_nxt;

   // Walk pointer and the next ID to hand out.
   port_idx_t ptr_port;
   q_idx_t    ptr_entry;
   id_idx_t   next_id;
   logic      step;

   // Byte offset of the pointed entry within the port's buffer.
   logic [63:0] entry_off;

   always_comb begin
      state_nxt = state;
      step      = 1'b0;
      case (state)
         st_idle: begin
            if (run) state_nxt = st_start;
         end
         st_start: begin
            // Skip entries that are valid or in flight.
            if (entry_busy[ptr_port][ptr_entry]) step = 1'b1;
            else if (!id_busy[next_id]) state_nxt = st_read_inst;
         end
         // Instruction table read takes one cycle.
         st_read_inst: state_nxt = st_addr;
         st_addr: begin
            if (ar_ready) begin
               state_nxt = st_start;
               step      = 1'b1;
            end
         end
         default: state_nxt = st_idle;
      endcase
   end

   // ------------------------------------------------
   // State, pointer and ID registers.
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (!sync_rst_n || !run) begin
         state     <= st_idle;
         ptr_port  <= '0;
         ptr_entry <= '0;
         next_id   <= '0;
      end else begin
         state <= state_nxt;
         if (step) begin
            // Last entry of the port, move to the next port.
            if (ptr_entry == q_size[ptr_port]) begin
               ptr_entry <= '0;
               if (ptr_port == port_idx_t'(inst_count - 1'b1)) ptr_port <= '0;
               else ptr_port <= ptr_port + 1'b1;
            end else begin
               ptr_entry <= ptr_entry + 1'b1;
            end
         end
         // IDs cycle round robin on each handshake.
         if (issue) next_id <= next_id + 1'b1;
      end
   end

   assign inst_rd_index = ptr_port;

   // Entries are (len + 1) beats apart.
   assign entry_off = ((64'(inst.len) + 64'd1) * 64'(ptr_entry)) << beat_bytes_log2;

   // Address channel payload, built while the instruction is out.
   always_ff @(posedge clk) begin
      if (state == st_read_inst) begin
         ar.id   <= axi_id_t'(next_id);
         ar.addr <= inst.addr + entry_off;
         ar.len  <= inst.len;
         ar.size <= 3'(beat_bytes_log2);
      end
   end

   assign ar_valid = (state == st_addr);

   // Handshake marks the entry and the ID as taken.
   assign issue       = ar_valid && ar_ready;
   assign issue_id    = next_id;
   assign issue_port  = ptr_port;
   assign issue_entry = ptr_entry;

   // Request held steady under back-pressure.
   a_ar_stable: assert property (@(posedge clk) disable iff (!sync_rst_n || !run)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar));

endmodule

/* design/pcir_read_queues.sv */
// ------------------------------------------------
// Per-port read queues: response capture by ID and
// the delivery FSM that feeds the DUT each cycle.
// ------------------------------------------------
module pcir_read_queues
   import pcir_cfg_pkg::*;
   import pcir_axi_pkg::*;
(
   input  logic                              clk,
   input  logic                              sync_rst_n,
   input  logic                              run,
   input  q_size_arr_t                       q_size,
   input  logic                              issue,
   input  id_idx_t                           issue_id,
   input  port_idx_t                         issue_port,
   input  q_idx_t                            issue_entry,
   output logic [num_ports-1:0][q_depth-1:0] entry_busy,
   output logic [num_ids-1:0]                id_busy,
   input  axi_r_t                            r,
   input  logic                              r_valid,
   output logic                              r_ready,
   input  logic [num_ports-1:0]              inst_active,
   input  logic                              dut_clocked,
   output port_data_t [num_ports-1:0]        port_data,
   output logic                              read_sm_active,
   output logic                              dut_cycle_done
);

   typedef enum logic [1:0] {
      dl_idle,
      dl_busy,
      dl_wait
   } dlv_state_t;

   dlv_state_t state, state_nxt;

   // Target of each outstanding ID.
   port_idx_t [num_ids-1:0] id_port;
   q_idx_t    [num_ids-1:0] id_entry;
   logic      [num_ids-1:0] id_got_first;

   // Queue storage and status.
   port_data_t [num_ports-1:0][q_depth-1:0] q_data;
   logic       [num_ports-1:0][q_depth-1:0] q_issued;
   logic       [num_ports-1:0][q_depth-1:0] q_vld;
   q_idx_t     [num_ports-1:0]              head;
   logic       [num_ports-1:0]              sent;
   logic       [num_ports-1:0]              load;

   // Decoded response beat.
   logic      beat;
   id_idx_t   rid;
   port_idx_t r_port;
   q_idx_t    r_entry;

   // Responses are never back-pressured.
   assign r_ready = 1'b1;

   assign beat    = r_valid && r_ready;
   assign rid     = id_idx_t'(r.id);
   assign r_port  = id_port[rid];
   assign r_entry = id_entry[rid];

   assign entry_busy = q_issued | q_vld;

   // Record where each new ID's data goes.
   always_ff @(posedge clk) begin
      if (issue) begin
         id_port[issue_id]  <= issue_port;
         id_entry[issue_id] <= issue_entry;
      end
   end

   // First beat only, later beats are dropped.
   always_ff @(posedge clk) begin
      if (beat && !id_got_first[rid]) begin
         q_data[r_port][r_entry] <= r.data;
      end
   end

   // ------------------------------------------------
   // Delivery FSM.
   // ------------------------------------------------
   always_comb begin
      state_nxt = state;
      case (state)
         dl_idle: begin
            if (run) state_nxt = dl_busy;
         end
         dl_busy: begin
            // Every active port has its word.
            if (&(sent | ~inst_active)) state_nxt = dl_wait;
         end
         dl_wait: begin
            if (dut_clocked) state_nxt = dl_busy;
         end
         default: state_nxt = dl_idle;
      endcase
   end

   assign read_sm_active = (state == dl_busy);
   assign dut_cycle_done = (state == dl_wait) && dut_clocked;

   // Ports whose head entry is ready to present.
   always_comb begin
      for (int p = 0; p < num_ports; p++) begin
         load[p] = read_sm_active && inst_active[p] && !sent[p] && q_vld[p][head[p]];
      end
   end

   always_ff @(posedge clk) begin
      if (!sync_rst_n) begin
         port_data <= '0;
      end else begin
         for (int p = 0; p < num_ports; p++) begin
            if (load[p]) port_data[p] <= q_data[p][head[p]];
         end
      end
   end

   // ------------------------------------------------
   // Status bits, cleared whenever the run stops.
   // ------------------------------------------------
   always_ff @(posedge clk) begin
      if (!sync_rst_n || !run) begin
         state        <= dl_idle;
         id_busy      <= '0;
         id_got_first <= '0;
         q_issued     <= '0;
         q_vld        <= '0;
         head         <= '0;
         sent         <= '0;
      end else begin
         state <= state_nxt;
         sent  <= sent | load;
         // Last beat completes the entry and frees the ID.
         if (beat) begin
            id_got_first[rid] <= 1'b1;
            if (r.last) begin
               q_vld[r_port][r_entry]    <= 1'b1;
               q_issued[r_port][r_entry] <= 1'b0;
               id_busy[rid]              <= 1'b0;
            end
         end
         // Issue never targets an ID or entry in use.
         if (issue) begin
            id_busy[issue_id]                 <= 1'b1;
            id_got_first[issue_id]            <= 1'b0;
            q_issued[issue_port][issue_entry] <= 1'b1;
         end
         // DUT took the data, retire the head entries.
         if (dut_cycle_done) begin
            sent <= '0;
            for (int p = 0; p < num_ports; p++) begin
               if (inst_active[p]) begin
                  q_vld[p][head[p]] <= 1'b0;
                  head[p] <= (head[p] == q_size[p]) ? '0 : head[p] + 1'b1;
               end
            end
         end
      end
   end

   // Every beat answers a read that is still outstanding.
   a_r_id_busy: assert property (@(posedge clk) disable iff (!sync_rst_n || !run)
      beat |-> (r.id < num_ids) && id_busy[rid]);

endmodule

/* test/pcir_tb_tasks.svh */
// --------------------------------------------------
// Testbench tasks for config access, waits, compares
// and the directed tests of the read master.
// --------------------------------------------------
`ifndef PCIR_TB_TASKS_SVH
`define PCIR_TB_TASKS_SVH

// --------------------------------------------------
// Failure and compare tasks.
// --------------------------------------------------
task automatic fail_stop(input string msg);
   $display("%s", msg);
   $display("TEST FAILED");
   $fatal(1);
endtask

task automatic check_rdata(input string name, input cfg_rsp_t rsp, input logic [31:0] exp);
   if (rsp.rdata !== exp)
      fail_stop($sformatf("** Error: %s = 0x%h, expected 0x%h", name, rsp.rdata, exp));
endtask

task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
   if (got !== exp)
      fail_stop($sformatf("** Error: ar id/addr/len/size 0x%h/0x%h/0x%h/0x%h, expected %s",
                          got.id, got.addr, got.len, got.size,
                          $sformatf("0x%h/0x%h/0x%h/0x%h", exp.id, exp.addr, exp.len, exp.size)));
endtask

task automatic check_port(input string name, input port_data_t got, input port_data_t exp);
   if (got !== exp)
      fail_stop($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
endtask

// Entries of a port sit (len + 1) beats of 8 bytes apart.
function automatic logic [63:0] entry_addr(input logic [63:0] base, input logic [7:0] len,
                                           input int entry);
   return base + (64'(len) + 64'd1) * 64'(entry) * 64'd8;
endfunction

// First beat of an entry as the memory model returns it.
function automatic port_data_t exp_data(input logic [63:0] base, input logic [7:0] len,
                                        input int entry);
   return entry_addr(base, len, entry) ^ data_mask;
endfunction

// --------------------------------------------------
// Config bus access.
// --------------------------------------------------
task automatic cfg_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output cfg_rsp_t rsp);
   int n;
   @(negedge clk);
   cfg_req = '{addr: addr, wdata: wdata, wr: wr, rd: !wr};
   n = 0;
   // Drop the strobe after one cycle and wait for the ack.
   do begin
      @(negedge clk);
      cfg_req = '0;
      n++;
   end while (!cfg_rsp.ack && n < 20);
   if (!cfg_rsp.ack) fail_stop("Config access got no acknowledge.");
   if (n != 2) fail_stop($sformatf("Config acknowledge came %0d cycles after the strobe.", n));
   rsp = cfg_rsp;
endtask

task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
   cfg_rsp_t rsp;
   cfg_access(1'b1, addr, data, rsp);
endtask

task automatic read_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
   cfg_rsp_t rsp;
   cfg_access(1'b0, addr, 32'h0, rsp);
   check_rdata(name, rsp, exp);
endtask

// --------------------------------------------------
// Waits with their own timeouts.
// --------------------------------------------------
task automatic wait_sm(input logic level);
   int n;
   n = 0;
   while (read_sm_active !== level && n < 1000) begin
      @(negedge clk);
      n++;
   end
   if (read_sm_active !== level)
      fail_stop($sformatf("Timed out waiting for read_sm_active to become %0b.", level));
endtask

task automatic wait_requests(input int count);
   int n;
   n = 0;
   while (ar_log.size() < count && n < 2000) begin
      @(negedge clk);
      n++;
   end
   if (ar_log.size() < count)
      fail_stop($sformatf("Timed out waiting for %0d read requests.", count));
endtask

// No request pending and no address on the bus for 16 cycles.
task automatic quiesce();
   int quiet;
   int n;
   quiet = 0;
   n = 0;
   while (quiet < 16 && n < 2000) begin
      @(negedge clk);
      if (pend_q.size() == 0 && !in_burst && !ar_valid) quiet++;
      else quiet = 0;
      n++;
   end
   if (quiet < 16) fail_stop("Timed out waiting for the AXI traffic to drain.");
endtask

// --------------------------------------------------
// Setup and run control.
// --------------------------------------------------
task automatic apply_reset();
   sync_rst_n  = 1'b0;
   cfg_req     = '0;
   inst_active = '0;
   dut_clocked = 1'b0;
   repeat (10) @(negedge clk);
   sync_rst_n = 1'b1;
endtask

// Length write commits the instruction.
task automatic setup_port(input int port, input logic [63:0] base, input logic [7:0] len);
   write_reg(reg_inst_index, 32'(port));
   write_reg(reg_addr_lo, base[31:0]);
   write_reg(reg_addr_hi, base[63:32]);
   write_reg(reg_len, 32'(len));
endtask

task automatic start_run(input logic [31:0] count, input logic [31:0] qsz,
                         input logic [31:0] limit);
   write_reg(reg_inst_count, count);
   write_reg(reg_q_size, qsz);
   write_reg(reg_run_cycles, limit);
   write_reg(reg_run, 32'd1);
   wait_sm(1'b1);
endtask

task automatic stop_run();
   quiesce();
   write_reg(reg_run, 32'd0);
endtask

task automatic pulse_clocked();
   @(negedge clk);
   dut_clocked = 1'b1;
   @(negedge clk);
   dut_clocked = 1'b0;
endtask

// Each cycle presents the next entry of every active port.
task automatic deliver_check(input int ncyc, input logic [7:0] len, input int qsz);
   for (int k = 0; k < ncyc; k++) begin
      wait_sm(1'b0);
      for (int p = 0; p < num_ports; p++) begin
         if (inst_active[p])
            check_port($sformatf("port_data[%0d]", p), port_data[p],
                       exp_data(bases[p], len, k % (qsz + 1)));
      end
      pulse_clocked();
   end
endtask

// --------------------------------------------------
// Directed tests.
// --------------------------------------------------
task automatic test_regs();
   @(negedge clk);
   if (ar_valid !== 1'b0 || read_sm_active !== 1'b0 || cfg_rsp.ack !== 1'b0)
      fail_stop($sformatf("** Error: ar_valid 0x%h read_sm_active 0x%h ack 0x%h, expected 0x0",
                          ar_valid, read_sm_active, cfg_rsp.ack));
   // Port data words start cleared.
   for (int p = 0; p < num_ports; p++)
      check_port($sformatf("port_data[%0d]", p), port_data[p], 64'h0);
   write_reg(reg_run_cycles, 32'h1234_5678);
   write_reg(reg_inst_count, 32'd1);
   write_reg(reg_inst_index, 32'd1);
   write_reg(reg_addr_lo, 32'hCAFE_0008);
   write_reg(reg_addr_hi, 32'h0000_00A5);
   write_reg(reg_len, 32'h0000_00AB);
   write_reg(reg_q_size, 32'h0000_000B);
   read_reg("reg_run", reg_run, 32'd0);
   read_reg("reg_run_cycles", reg_run_cycles, 32'h1234_5678);
   read_reg("reg_inst_count", reg_inst_count, 32'd1);
   read_reg("reg_inst_index", reg_inst_index, 32'd1);
   read_reg("reg_addr_lo", reg_addr_lo, 32'hCAFE_0008);
   read_reg("reg_addr_hi", reg_addr_hi, 32'h0000_00A5);
   read_reg("reg_len", reg_len, 32'h0000_00AB);
   read_reg("reg_q_size", reg_q_size, 32'h0000_000B);
   read_reg("reg_dut_cycles", reg_dut_cycles, 32'd0);
   read_reg("unmapped 0x24", 8'h24, 32'hDEAD_BEEF);
endtask

task automatic test_single();
   axi_ar_t exp;
   inst_active = 2'b01;
   setup_port(0, bases[0], 8'd0);
   ar_log.delete();
   start_run(32'd1, 32'd0, 32'hFFFF_FFFF);
   wait_requests(1);
   exp = '{id: 16'd0, addr: bases[0], len: 8'd0, size: 3'd3};
   check_ar(ar_log[0], exp);
   wait_sm(1'b0);
   check_port("port_data[0]", port_data[0], exp_data(bases[0], 8'd0, 0));
   stop_run();
endtask

// Port 0 entries 0 to 3 come before port 1 entries 0 to 3.
task automatic test_walk();
   axi_ar_t exp;
   inst_active = 2'b11;
   setup_port(0, bases[0], 8'd1);
   setup_port(1, bases[1], 8'd1);
   ar_log.delete();
   start_run(32'd2, 32'hF, 32'hFFFF_FFFF);
   wait_requests(8);
   for (int i = 0; i < 8; i++) begin
      exp = '{id: 16'(i % 4), addr: entry_addr(bases[i / 4], 8'd1, i % 4),
              len: 8'd1, size: 3'd3};
      check_ar(ar_log[i], exp);
   end
endtask

// Continues the run started by the walk test.
task automatic test_delivery();
   deliver_check(12, 8'd1, 3);
   stop_run();
endtask

task automatic test_run_limit();
   apply_reset();
   inst_active = 2'b11;
   setup_port(0, bases[0], 8'd1);
   setup_port(1, bases[1], 8'd1);
   start_run(32'd2, 32'hF, 32'd3);
   deliver_check(3, 8'd1, 3);
   // Run drops on the last cycle and the FSMs idle one cycle later.
   @(negedge clk);
   for (int n = 0; n < 20; n++) begin
      if (ar_valid !== 1'b0 || read_sm_active !== 1'b0)
         fail_stop($sformatf("** Error: ar_valid 0x%h read_sm_active 0x%h, expected 0x0",
                             ar_valid, read_sm_active));
      @(negedge clk);
   end
   read_reg("reg_dut_cycles", reg_dut_cycles, 32'd3);
endtask

`endif

/* test/pcir_mstr_tb.sv */
// --------------------------------------------------
// Read master testbench with clock, reset, AXI memory
// responder and the directed test sequence.
// --------------------------------------------------
module pcir_mstr_tb
   import pcir_cfg_pkg::*;
   import pcir_axi_pkg::*;
();

   // Memory data is the beat address under this mask.
   localparam logic [63:0] data_mask = 64'hA5A5_0000_0000_5A5A;

   logic                       clk;
   logic                       sync_rst_n;
   cfg_req_t                   cfg_req;
   cfg_rsp_t                   cfg_rsp;
   axi_ar_t                    ar;
   logic                       ar_valid;
   logic                       ar_ready;
   axi_r_t                     r;
   logic                       r_valid;
   logic                       r_ready;
   logic [num_ports-1:0]       inst_active;
   logic                       dut_clocked;
   port_data_t [num_ports-1:0] port_data;
   logic                       read_sm_active;

   // Responder state.
   integer  seed = 32'h2454;
   axi_ar_t pend_q[$];
   axi_ar_t ar_log[$];
   axi_ar_t cur;
   int      beat_n;
   int      pick;
   logic    in_burst;

   // Buffer base of each port.
   logic [63:0] bases [num_ports];

   pcir_mstr_top u_dut (
      .clk, .sync_rst_n, .cfg_req, .cfg_rsp, .ar, .ar_valid, .ar_ready,
      .r, .r_valid, .r_ready, .inst_active, .dut_clocked, .port_data, .read_sm_active
   );

   `include "pcir_tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // --------------------------------------------------
   // AXI memory responder driven on the falling edge.
   // --------------------------------------------------
   always @(negedge clk) begin
      if (!sync_rst_n) begin
         pend_q.delete();
         in_burst = 1'b0;
         ar_ready = 1'b0;
         r_valid  = 1'b0;
      end else begin
         // Only requests from earlier handshakes are answered.
         r_valid = 1'b0;
         if (!in_burst && pend_q.size() > 0 && {$random(seed)} % 2 == 0) begin
            // Any outstanding ID may go next.
            pick = {$random(seed)} % pend_q.size();
            cur  = pend_q[pick];
            pend_q.delete(pick);
            beat_n   = 0;
            in_burst = 1'b1;
         end
         if (in_burst && {$random(seed)} % 4 != 0) begin
            r.id    = cur.id;
            r.data  = (cur.addr + 64'(beat_n * 8)) ^ data_mask;
            r.resp  = 2'b00;
            r.last  = (beat_n == int'(cur.len));
            r_valid = 1'b1;
            // The beat must be taken in the cycle it is driven.
            if (r_ready !== 1'b1)
               fail_stop($sformatf("** Error: r_ready = 0x%h, expected 0x1", r_ready));
            if (r.last) in_burst = 1'b0;
            beat_n++;
         end
         // Random stalls on the address channel.
         ar_ready = {$random(seed)} % 3 != 0;
         // Handshake completes on the coming rising edge.
         if (ar_valid && ar_ready) begin
            pend_q.push_back(ar);
            ar_log.push_back(ar);
         end
      end
   end

   // Hard limit on the whole run.
   initial begin
      #2000000;
      fail_stop("Simulation ran past its time limit.");
   end

   // --------------------------------------------------
   // Test sequence.
   // --------------------------------------------------
   initial begin
      sync_rst_n  = 1'b0;
      cfg_req     = '0;
      ar_ready    = 1'b0;
      r           = '0;
      r_valid     = 1'b0;
      inst_active = '0;
      dut_clocked = 1'b0;
      in_burst    = 1'b0;
      bases[0]    = 64'h0000_0001_0000_1000;
      bases[1]    = 64'h0000_0002_8000_4000;
      apply_reset();
      test_regs();
      test_single();
      test_walk();
      test_delivery();
      test_run_limit();
      $display("TEST OK");
      $finish;
   end

endmodule
